//--- core_mem_port.f
mem_qos_pkg.sv
qos_policy.sv
port_arbiter.sv
rsp_router.sv
qos_monitor.sv
core_mem_port.sv
core_mem_port_checker.sv
tb_core_mem_port.sv

//--- Makefile
# Verilator simulation of the core memory port

TOP       ?= tb_core_mem_port
SEED      ?= 30
LOG       ?= sim.log
FILELIST  ?= core_mem_port.f
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_FLAGS ?= +verilator+error+limit+1000

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: build run clean

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) \
		-f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(SIM_BIN) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "Testbench passed" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_core_mem_port.sv
`timescale 1ns/100ps
`default_nettype none

module tb_core_mem_port
    import mem_qos_pkg::*;
#(
    parameter int SEED = 30
);

    localparam int unsigned CORE_ID           = 3;
    localparam int unsigned OUTSTANDING_DEPTH = 4;
    localparam int unsigned RANDOM_REQS       = 60;
    localparam int unsigned WAIT_LIMIT        = 2000;

    logic        clk_i = 1'b0;
    logic        rst_ni;
    logic        ireq_valid_i, ireq_ready_o, irsp_valid_o, irsp_ready_i;
    logic        dreq_valid_i, dreq_ready_o, drsp_valid_o, drsp_ready_i;
    mem_req_t    ireq_i, dreq_i, mem_req_o;
    mem_rsp_t    irsp_o, drsp_o, mem_rsp_i;
    logic        mem_req_valid_o, mem_req_ready_i, mem_rsp_valid_i, mem_rsp_ready_o;
    qos_config_t mem_qos_o, core_qos_i;
    logic        qos_enable_i, exception_pending_i;
    count_t      qos_violations_o, instr_grants_o, data_grants_o;

    int          seed;
    int unsigned err_count     = 0;
    int unsigned timeout_count = 0;
    int unsigned viol_count    = 0;
    int unsigned i_grants      = 0;
    int unsigned d_grants      = 0;
    // Handshake flags from the last rising edge
    logic        i_fired = 1'b0;
    logic        d_fired = 1'b0;
    logic        rsp_taken = 1'b0;
    logic        stall_seen = 1'b0;
    logic        rsp_hold = 1'b0;
    // Scoreboard and memory model queues hold the oldest entry first
    src_t        sb_src[$];
    mem_rsp_t    sb_rsp[$];
    addr_t       mem_addr_q[$];
    int          mem_delay_q[$];

    always #2 clk_i = ~clk_i;

    core_mem_port #(
        .CORE_ID           (CORE_ID),
        .OUTSTANDING_DEPTH (OUTSTANDING_DEPTH)
    ) DUT (.*);

    bind core_mem_port core_mem_port_checker #(
        .OUTSTANDING_DEPTH (OUTSTANDING_DEPTH)
    ) u_checker (
        .clk_i (clk_i), .rst_ni (rst_ni),
        .ireq_ready_i (ireq_ready_o), .dreq_ready_i (dreq_ready_o),
        .irsp_valid_i (irsp_valid_o), .drsp_valid_i (drsp_valid_o),
        .mem_req_valid_i (mem_req_valid_o), .mem_req_i (mem_req_o),
        .mem_qos_i (mem_qos_o), .mem_req_ready_i (mem_req_ready_i),
        .mem_rsp_valid_i (mem_rsp_valid_i), .mem_rsp_ready_i (mem_rsp_ready_o)
    );

    // ------------------------------------------------------------
    // Reference rules
    // ------------------------------------------------------------

    function automatic qos_config_t policy_qos(input logic is_data, input logic store);
        qos_config_t q;
        q.core_id     = 4'(CORE_ID);
        q.urgent      = exception_pending_i;
        q.preemptable = !exception_pending_i;
        if (exception_pending_i) begin
            q.level       = QOS_LEVEL_CRITICAL;
            q.weight      = QOS_WEIGHT_CRITICAL;
            q.max_latency = is_data ? 16'd10 : 16'd5;
        end else if (!is_data) begin
            q.level       = QOS_LEVEL_HIGH;
            q.weight      = QOS_WEIGHT_HIGH;
            q.max_latency = 16'd25;
        end else if (store) begin
            q.level       = QOS_LEVEL_MEDIUM;
            q.weight      = QOS_WEIGHT_MEDIUM;
            q.max_latency = 16'd100;
        end else begin
            q.level       = QOS_LEVEL_MEDIUM_HIGH;
            q.weight      = QOS_WEIGHT_MEDIUM_HIGH;
            q.max_latency = 16'd50;
        end
        return q;
    endfunction

    // Instruction wins a tie unless QoS is on and an exception is pending
    function automatic logic instr_expected_to_win();
        if (ireq_valid_i && dreq_valid_i) begin
            return qos_enable_i ? !exception_pending_i : 1'b1;
        end
        return ireq_valid_i;
    endfunction

    // Read data depends on every address bit
    function automatic mem_rsp_t model_rsp(input addr_t addr);
        mem_rsp_t rsp;
        rsp.rdata = {addr[15:0], addr[31:16]} ^ 32'h5A5A_C3C3;
        rsp.error = ^addr;
        return rsp;
    endfunction

    task automatic check_val(input string name, input logic [95:0] actual,
                             input logic [95:0] expected);
        assert (actual === expected) else begin
            $display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
            err_count++;
        end
    endtask

    task automatic make_req(input logic write, output mem_req_t req);
        req.addr  = addr_t'($random(seed)) & 32'hFFFF_FFFC;
        req.write = write;
        req.strb  = write ? strb_t'($random(seed)) : 4'hF;
        req.wdata = write ? word_t'($random(seed)) : '0;
    endtask

    // ------------------------------------------------------------
    // Scoreboard samples before the edge updates anything
    // ------------------------------------------------------------

    always @(posedge clk_i) begin : scoreboard
        logic     exp_valid;
        logic     instr_win;
        logic     head_instr;
        logic     head_data;
        mem_req_t win_req;
        i_fired   = 1'b0;
        d_fired   = 1'b0;
        rsp_taken = 1'b0;
        if (rst_ni) begin
            exp_valid  = (ireq_valid_i || dreq_valid_i) && (sb_src.size() < OUTSTANDING_DEPTH);
            instr_win  = instr_expected_to_win();
            win_req    = instr_win ? ireq_i : dreq_i;
            head_instr = (sb_src.size() != 0) && (sb_src[0] == SRC_INSTR);
            head_data  = (sb_src.size() != 0) && (sb_src[0] == SRC_DATA);
            check_val("mem_req_valid_o", mem_req_valid_o, exp_valid);
            check_val("ireq_ready_o", ireq_ready_o, exp_valid && instr_win && mem_req_ready_i);
            check_val("dreq_ready_o", dreq_ready_o, exp_valid && !instr_win && mem_req_ready_i);
            if (exp_valid) begin
                check_val("mem_req_o", mem_req_o, win_req);
                check_val("mem_qos_o", mem_qos_o, !qos_enable_i ? core_qos_i :
                          policy_qos(!instr_win, dreq_i.write));
            end
            // Response steering follows the oldest outstanding source
            check_val("irsp_valid_o", irsp_valid_o, mem_rsp_valid_i && head_instr);
            check_val("drsp_valid_o", drsp_valid_o, mem_rsp_valid_i && head_data);
            check_val("mem_rsp_ready_o", mem_rsp_ready_o,
                      (head_instr && irsp_ready_i) || (head_data && drsp_ready_i));
            if (mem_rsp_valid_i && ((head_instr && irsp_ready_i) || (head_data && drsp_ready_i))) begin
                check_val(head_instr ? "irsp_o" : "drsp_o",
                          head_instr ? irsp_o : drsp_o, sb_rsp[0]);
                void'(sb_src.pop_front());
                void'(sb_rsp.pop_front());
                rsp_taken = 1'b1;
            end
            if (exp_valid && mem_req_ready_i) begin
                sb_src.push_back(instr_win ? SRC_INSTR : SRC_DATA);
                sb_rsp.push_back(model_rsp(win_req.addr));
                mem_addr_q.push_back(win_req.addr);
                mem_delay_q.push_back($random(seed) & 3);
                i_fired = instr_win;
                d_fired = !instr_win;
                if (instr_win) i_grants++;
                else d_grants++;
            end
            stall_seen = exp_valid && !mem_req_ready_i;
            if (stall_seen && qos_enable_i) viol_count++;
        end
    end

    // Memory answers in order after the delay drawn at acceptance
    initial begin : memory_model
        mem_rsp_valid_i = 1'b0;
        mem_rsp_i       = '0;
        forever begin
            @(negedge clk_i);
            if (rsp_taken) mem_rsp_valid_i = 1'b0;
            if (!mem_rsp_valid_i && !rsp_hold && mem_addr_q.size() != 0) begin
                if (mem_delay_q[0] == 0) begin
                    mem_rsp_i       = model_rsp(mem_addr_q.pop_front());
                    mem_rsp_valid_i = 1'b1;
                    void'(mem_delay_q.pop_front());
                end else begin
                    mem_delay_q[0] = mem_delay_q[0] - 1;
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------

    task automatic finish_run();
        int unsigned chk_errs;
        chk_errs = DUT.u_checker.fail_count;
        $display("Errors: %0d value, %0d assertion, %0d timeout",
                 err_count, chk_errs, timeout_count);
        if (timeout_count != 0 || err_count != 0 || chk_errs != 0) begin
            $display("Testbench failed");
        end else begin
            $display("Testbench passed");
        end
        $finish;
    endtask

    // Raise the chosen streams and hold each until accepted
    task automatic send_requests(input logic send_i, input logic send_d,
                                 input mem_req_t i_req, input mem_req_t d_req);
        int unsigned cycles;
        @(negedge clk_i);
        ireq_i       = i_req;
        dreq_i       = d_req;
        ireq_valid_i = send_i;
        dreq_valid_i = send_d;
        cycles       = 0;
        while ((ireq_valid_i || dreq_valid_i) && cycles < WAIT_LIMIT) begin
            @(negedge clk_i);
            if (i_fired) ireq_valid_i = 1'b0;
            if (d_fired) dreq_valid_i = 1'b0;
            cycles++;
        end
        if (ireq_valid_i || dreq_valid_i) begin
            $display("Timeout: request was never accepted by the port");
            timeout_count++;
        end
    endtask

    task automatic wait_drain();
        int unsigned cycles;
        cycles = 0;
        @(negedge clk_i);
        while (sb_src.size() != 0 && cycles < WAIT_LIMIT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (sb_src.size() != 0) begin
            $display("Timeout: responses still outstanding after the drain wait");
            timeout_count++;
        end
    endtask

    initial begin : stimulus
        mem_req_t    i_req;
        mem_req_t    d_req;
        int unsigned issued;
        int unsigned cycles;
        seed = SEED;
        rst_ni = 1'b0;
        {ireq_valid_i, dreq_valid_i, irsp_ready_i, drsp_ready_i} = 4'b0011;
        ireq_i = '0;
        dreq_i = '0;
        mem_req_ready_i     = 1'b1;
        qos_enable_i        = 1'b1;
        exception_pending_i = 1'b0;
        core_qos_i          = qos_config_t'($random(seed));
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        // With QoS on the fetch goes first and a pending exception favours data
        make_req(1'b0, i_req);
        make_req(1'b0, d_req);
        send_requests(1'b1, 1'b1, i_req, d_req);
        wait_drain();
        exception_pending_i = 1'b1;
        make_req(1'b1, d_req);
        send_requests(1'b1, 1'b1, i_req, d_req);
        wait_drain();
        exception_pending_i = 1'b0;
        // Data alone as a store and then a load
        send_requests(1'b0, 1'b1, i_req, d_req);
        make_req(1'b0, d_req);
        send_requests(1'b0, 1'b1, i_req, d_req);
        wait_drain();
        // QoS off gives fixed priority and the core sideband
        qos_enable_i = 1'b0;
        send_requests(1'b1, 1'b1, i_req, d_req);
        wait_drain();
        qos_enable_i = 1'b1;

        // Fill the tracker so a further fetch must wait for a response
        rsp_hold = 1'b1;
        repeat (OUTSTANDING_DEPTH) send_requests(1'b0, 1'b1, i_req, d_req);
        ireq_valid_i = 1'b1;
        repeat (4) @(negedge clk_i);
        rsp_hold = 1'b0;
        cycles = 0;
        while (!i_fired && cycles < WAIT_LIMIT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (!i_fired) begin
            $display("Timeout: fetch stayed blocked after the tracker drained");
            timeout_count++;
        end
        ireq_valid_i = 1'b0;
        wait_drain();

        // Random mix with back-pressure on every channel
        issued = 0;
        cycles = 0;
        while ((issued < RANDOM_REQS || ireq_valid_i || dreq_valid_i) && cycles < WAIT_LIMIT) begin
            @(negedge clk_i);
            cycles++;
            if (i_fired) ireq_valid_i = 1'b0;
            if (d_fired) dreq_valid_i = 1'b0;
            // New valids only when nothing is stalled so the winner holds
            if (!stall_seen && issued < RANDOM_REQS && !ireq_valid_i && ($random(seed) & 1)) begin
                make_req(1'b0, i_req);
                ireq_i       = i_req;
                ireq_valid_i = 1'b1;
                issued++;
            end
            if (!stall_seen && issued < RANDOM_REQS && !dreq_valid_i && ($random(seed) & 1)) begin
                make_req(($random(seed) & 1) != 0, d_req);
                dreq_i       = d_req;
                dreq_valid_i = 1'b1;
                issued++;
            end
            mem_req_ready_i = ($random(seed) & 3) != 0;
            irsp_ready_i    = ($random(seed) & 3) != 0;
            drsp_ready_i    = ($random(seed) & 3) != 0;
        end
        if (issued < RANDOM_REQS || ireq_valid_i || dreq_valid_i) begin
            $display("Timeout: random traffic did not complete");
            timeout_count++;
        end
        {mem_req_ready_i, irsp_ready_i, drsp_ready_i} = 3'b111;
        wait_drain();

        check_val("qos_violations_o", qos_violations_o, viol_count);
        check_val("instr_grants_o", instr_grants_o, i_grants);
        check_val("data_grants_o", data_grants_o, d_grants);
        finish_run();
    end

endmodule

`default_nettype wire

//--- core_mem_port_checker.sv
`timescale 1ns/100ps
`default_nettype none

module core_mem_port_checker
    import mem_qos_pkg::*;
#(
    parameter int unsigned OUTSTANDING_DEPTH = 4
) (
    input logic        clk_i,
    input logic        rst_ni,
    input logic        ireq_ready_i,
    input logic        dreq_ready_i,
    input logic        irsp_valid_i,
    input logic        drsp_valid_i,
    input logic        mem_req_valid_i,
    input mem_req_t    mem_req_i,
    input qos_config_t mem_qos_i,
    input logic        mem_req_ready_i,
    input logic        mem_rsp_valid_i,
    input logic        mem_rsp_ready_i
);

    // Number of failed assertions so far
    int unsigned fail_count = 0;

    // Requests accepted but not yet answered, kept apart from the router
    int unsigned outstanding_q;
    logic        req_fire;
    logic        rsp_fire;

    assign req_fire = mem_req_valid_i && mem_req_ready_i;
    assign rsp_fire = mem_rsp_valid_i && mem_rsp_ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            outstanding_q <= 0;
        end else if (req_fire && !rsp_fire) begin
            outstanding_q <= outstanding_q + 1;
        end else if (!req_fire && rsp_fire) begin
            outstanding_q <= outstanding_q - 1;
        end
    end

    // ------------------------------------------------------------
    // Port properties
    // ------------------------------------------------------------

    // At most one stream accepted per cycle
    a_one_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(ireq_ready_i && dreq_ready_i))
    else begin
        $error("both request readies high");
        fail_count++;
    end

    // Routed response needs an outstanding request
    a_rsp_tracked: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (irsp_valid_i || drsp_valid_i) |-> (outstanding_q != 0))
    else begin
        $error("response routed with empty tracker");
        fail_count++;
    end

    // Stalled request keeps payload and QoS sideband
    a_stall_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mem_req_valid_i && !mem_req_ready_i) |=>
            (mem_req_valid_i && $stable(mem_req_i) && $stable(mem_qos_i)))
    else begin
        $error("stalled request changed");
        fail_count++;
    end

    a_full_blocks: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (outstanding_q == OUTSTANDING_DEPTH) |-> !mem_req_valid_i)
    else begin
        $error("request issued with full tracker");
        fail_count++;
    end

endmodule

`default_nettype wire

//--- core_mem_port.sv
`timescale 1ns/100ps
`default_nettype none

module core_mem_port
    import mem_qos_pkg::*;
#(
    parameter int unsigned CORE_ID           = 0,
    parameter int unsigned OUTSTANDING_DEPTH = 4
) (
    input  logic        clk_i,
    input  logic        rst_ni,

    // Instruction side
    input  logic        ireq_valid_i,
    input  mem_req_t    ireq_i,
    output logic        ireq_ready_o,
    output logic        irsp_valid_o,
    output mem_rsp_t    irsp_o,
    input  logic        irsp_ready_i,

    // Data side
    input  logic        dreq_valid_i,
    input  mem_req_t    dreq_i,
    output logic        dreq_ready_o,
    output logic        drsp_valid_o,
    output mem_rsp_t    drsp_o,
    input  logic        drsp_ready_i,

    // Merged memory side
    output logic        mem_req_valid_o,
    output mem_req_t    mem_req_o,
    output qos_config_t mem_qos_o,
    input  logic        mem_req_ready_i,
    input  logic        mem_rsp_valid_i,
    input  mem_rsp_t    mem_rsp_i,
    output logic        mem_rsp_ready_o,

    // Control
    input  logic        qos_enable_i,
    input  logic        exception_pending_i,
    input  qos_config_t core_qos_i,

    // Counters
    output count_t      qos_violations_o,
    output count_t      instr_grants_o,
    output count_t      data_grants_o
);

    qos_config_t instr_qos;
    qos_config_t data_qos;
    src_t        grant_src;
    logic        req_fire;
    logic        tracker_full;

    // ------------------------------------------------------------
    // Request path
    // ------------------------------------------------------------

    // Write flag picks the store or load config
    qos_policy #(
        .CORE_ID (CORE_ID)
    ) u_qos_policy (
        .exception_pending_i (exception_pending_i),
        .data_is_store_i     (dreq_i.write),
        .instr_qos_o         (instr_qos),
        .data_qos_o          (data_qos)
    );

    port_arbiter u_port_arbiter (
        .qos_enable_i    (qos_enable_i),
        .ireq_valid_i    (ireq_valid_i),
        .ireq_i          (ireq_i),
        .ireq_ready_o    (ireq_ready_o),
        .dreq_valid_i    (dreq_valid_i),
        .dreq_i          (dreq_i),
        .dreq_ready_o    (dreq_ready_o),
        .instr_qos_i     (instr_qos),
        .data_qos_i      (data_qos),
        .core_qos_i      (core_qos_i),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_o       (mem_req_o),
        .mem_qos_o       (mem_qos_o),
        .mem_req_ready_i (mem_req_ready_i),
        .tracker_full_i  (tracker_full),
        .grant_src_o     (grant_src),
        .req_fire_o      (req_fire)
    );

    // ------------------------------------------------------------
    // Response path and monitoring
    // ------------------------------------------------------------

    rsp_router #(
        .OUTSTANDING_DEPTH (OUTSTANDING_DEPTH)
    ) u_rsp_router (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .req_fire_i      (req_fire),
        .grant_src_i     (grant_src),
        .tracker_full_o  (tracker_full),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_i       (mem_rsp_i),
        .mem_rsp_ready_o (mem_rsp_ready_o),
        .irsp_valid_o    (irsp_valid_o),
        .irsp_o          (irsp_o),
        .irsp_ready_i    (irsp_ready_i),
        .drsp_valid_o    (drsp_valid_o),
        .drsp_o          (drsp_o),
        .drsp_ready_i    (drsp_ready_i)
    );

    qos_monitor u_qos_monitor (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .qos_enable_i     (qos_enable_i),
        .mem_req_valid_i  (mem_req_valid_o),
        .mem_req_ready_i  (mem_req_ready_i),
        .grant_src_i      (grant_src),
        .req_fire_i       (req_fire),
        .qos_violations_o (qos_violations_o),
        .instr_grants_o   (instr_grants_o),
        .data_grants_o    (data_grants_o)
    );

endmodule

`default_nettype wire

//--- qos_monitor.sv
`timescale 1ns/100ps
`default_nettype none

module qos_monitor
    import mem_qos_pkg::*;
(
    input  logic   clk_i,
    input  logic   rst_ni,
    input  logic   qos_enable_i,
    input  logic   mem_req_valid_i,
    input  logic   mem_req_ready_i,
    input  src_t   grant_src_i,
    input  logic   req_fire_i,
    output count_t qos_violations_o,
    output count_t instr_grants_o,
    output count_t data_grants_o
);

    // Increment that sticks at all ones
    function automatic count_t sat_inc(input count_t value);
        return (value == '1) ? value : value + count_t'(1);
    endfunction

    logic stall_cycle;

    // Request waiting on a busy memory while QoS is on
    assign stall_cycle = qos_enable_i && mem_req_valid_i && !mem_req_ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            qos_violations_o <= '0;
            instr_grants_o   <= '0;
            data_grants_o    <= '0;
        end else begin
            if (stall_cycle) begin
                qos_violations_o <= sat_inc(qos_violations_o);
            end
            // Grants counted per accepted request
            if (req_fire_i && (grant_src_i == SRC_INSTR)) begin
                instr_grants_o <= sat_inc(instr_grants_o);
            end
            if (req_fire_i && (grant_src_i == SRC_DATA)) begin
                data_grants_o <= sat_inc(data_grants_o);
            end
        end
    end

endmodule

`default_nettype wire

//--- rsp_router.sv
`timescale 1ns/100ps
`default_nettype none

module rsp_router
    import mem_qos_pkg::*;
#(
    // Power of two, at least 2
    parameter int unsigned OUTSTANDING_DEPTH = 4
) (
    input  logic     clk_i,
    input  logic     rst_ni,

    // Accepted request from the arbiter
    input  logic     req_fire_i,
    input  src_t     grant_src_i,
    output logic     tracker_full_o,

    // Memory response channel
    input  logic     mem_rsp_valid_i,
    input  mem_rsp_t mem_rsp_i,
    output logic     mem_rsp_ready_o,

    // Routed responses
    output logic     irsp_valid_o,
    output mem_rsp_t irsp_o,
    input  logic     irsp_ready_i,
    output logic     drsp_valid_o,
    output mem_rsp_t drsp_o,
    input  logic     drsp_ready_i
);

    localparam int unsigned PTR_W = $clog2(OUTSTANDING_DEPTH);
    localparam int unsigned CNT_W = $clog2(OUTSTANDING_DEPTH + 1);

    // Source of each outstanding request, oldest at rd_ptr_q
    src_t             src_q [OUTSTANDING_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    logic tracker_empty;
    src_t head_src;
    logic rsp_fire;

    // ------------------------------------------------------------
    // Response steering
    // ------------------------------------------------------------

    assign tracker_empty  = (count_q == '0);
    assign tracker_full_o = (count_q == CNT_W'(OUTSTANDING_DEPTH));
    assign head_src       = src_q[rd_ptr_q];

    // Only the head owner sees valid
    assign irsp_valid_o = mem_rsp_valid_i && !tracker_empty && (head_src == SRC_INSTR);
    assign drsp_valid_o = mem_rsp_valid_i && !tracker_empty && (head_src == SRC_DATA);

    // Payload fans out, valid qualifies it
    assign irsp_o = mem_rsp_i;
    assign drsp_o = mem_rsp_i;

    always_comb begin
        if (tracker_empty) begin
            // Nothing expected back
            mem_rsp_ready_o = 1'b0;
        end else if (head_src == SRC_INSTR) begin
            mem_rsp_ready_o = irsp_ready_i;
        end else begin
            mem_rsp_ready_o = drsp_ready_i;
        end
    end

    assign rsp_fire = mem_rsp_valid_i && mem_rsp_ready_o;

    // ------------------------------------------------------------
    // Tracker update
    // ------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (req_fire_i) begin
            src_q[wr_ptr_q] <= grant_src_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            // Pointers wrap on their own with a power-of-two depth
            if (req_fire_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (rsp_fire) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(req_fire_i) - CNT_W'(rsp_fire);
        end
    end

endmodule

`default_nettype wire

//--- port_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module port_arbiter
    import mem_qos_pkg::*;
(
    input  logic        qos_enable_i,

    // Instruction request stream
    input  logic        ireq_valid_i,
    input  mem_req_t    ireq_i,
    output logic        ireq_ready_o,

    // Data request stream
    input  logic        dreq_valid_i,
    input  mem_req_t    dreq_i,
    output logic        dreq_ready_o,

    // Per-stream configs from the policy block
    input  qos_config_t instr_qos_i,
    input  qos_config_t data_qos_i,
    input  qos_config_t core_qos_i,

    // Merged request channel
    output logic        mem_req_valid_o,
    output mem_req_t    mem_req_o,
    output qos_config_t mem_qos_o,
    input  logic        mem_req_ready_i,

    // Router and monitor side
    input  logic        tracker_full_i,
    output src_t        grant_src_o,
    output logic        req_fire_o
);

    logic instr_beats_data;
    logic instr_wins;
    logic any_valid;
    logic can_issue;

    // ------------------------------------------------------------
    // Winner selection
    // ------------------------------------------------------------

    // QoS compare, only meaningful when both streams are valid
    always_comb begin
        if (instr_qos_i.level > data_qos_i.level) begin
            instr_beats_data = 1'b1;
        end else if (instr_qos_i.level == data_qos_i.level) begin
            // Equal level, urgency breaks the tie
            instr_beats_data = instr_qos_i.urgent && !data_qos_i.urgent;
        end else begin
            instr_beats_data = 1'b0;
        end
    end

    always_comb begin
        if (ireq_valid_i && dreq_valid_i) begin
            // Fixed instruction priority when QoS is off
            instr_wins = qos_enable_i ? instr_beats_data : 1'b1;
        end else begin
            instr_wins = ireq_valid_i;
        end
    end

    assign any_valid   = ireq_valid_i || dreq_valid_i;
    assign grant_src_o = instr_wins ? SRC_INSTR : SRC_DATA;

    // No new request without a free tracker slot
    assign can_issue = any_valid && !tracker_full_i;

    // ------------------------------------------------------------
    // Merged channel and per-port readies
    // ------------------------------------------------------------

    assign mem_req_valid_o = can_issue;
    assign mem_req_o       = instr_wins ? ireq_i : dreq_i;

    always_comb begin
        if (!qos_enable_i) begin
            mem_qos_o = core_qos_i;
        end else if (instr_wins) begin
            mem_qos_o = instr_qos_i;
        end else begin
            mem_qos_o = data_qos_i;
        end
    end

    // Loser sees ready low, winner follows memory ready
    assign ireq_ready_o = can_issue && instr_wins && mem_req_ready_i;
    assign dreq_ready_o = can_issue && !instr_wins && mem_req_ready_i;

    assign req_fire_o = can_issue && mem_req_ready_i;

endmodule

`default_nettype wire

//--- qos_policy.sv
`timescale 1ns/100ps
`default_nettype none

module qos_policy
    import mem_qos_pkg::*;
#(
    parameter int unsigned CORE_ID = 0
) (
    input  logic        exception_pending_i,
    input  logic        data_is_store_i,
    output qos_config_t instr_qos_o,
    output qos_config_t data_qos_o
);

    // Core id field is only 4 bits wide
    localparam core_id_t CORE_ID_FIELD = core_id_t'(CORE_ID);

    // ------------------------------------------------------------
    // Instruction fetch policy
    // ------------------------------------------------------------

    always_comb begin
        instr_qos_o.core_id = CORE_ID_FIELD;
        if (exception_pending_i) begin
            // Handler fetch must not be held off
            instr_qos_o.level       = QOS_LEVEL_CRITICAL;
            instr_qos_o.weight      = QOS_WEIGHT_CRITICAL;
            instr_qos_o.max_latency = QOS_LAT_INSTR_CRITICAL;
            instr_qos_o.urgent      = 1'b1;
            instr_qos_o.preemptable = 1'b0;
        end else begin
            instr_qos_o.level       = QOS_LEVEL_HIGH;
            instr_qos_o.weight      = QOS_WEIGHT_HIGH;
            instr_qos_o.max_latency = QOS_LAT_INSTR_NORMAL;
            instr_qos_o.urgent      = 1'b0;
            instr_qos_o.preemptable = 1'b1;
        end
    end

    // ------------------------------------------------------------
    // Data access policy
    // ------------------------------------------------------------

    always_comb begin
        data_qos_o.core_id = CORE_ID_FIELD;
        if (exception_pending_i) begin
            // Faulting access gets top level, beats instruction on urgency tie
            data_qos_o.level       = QOS_LEVEL_CRITICAL;
            data_qos_o.weight      = QOS_WEIGHT_CRITICAL;
            data_qos_o.max_latency = QOS_LAT_DATA_CRITICAL;
            data_qos_o.urgent      = 1'b1;
            data_qos_o.preemptable = 1'b0;
        end else if (data_is_store_i) begin
            // Stores can drain late
            data_qos_o.level       = QOS_LEVEL_MEDIUM;
            data_qos_o.weight      = QOS_WEIGHT_MEDIUM;
            data_qos_o.max_latency = QOS_LAT_STORE;
            data_qos_o.urgent      = 1'b0;
            data_qos_o.preemptable = 1'b1;
        end else begin
            // Loads stall the pipeline, so a bit higher
            data_qos_o.level       = QOS_LEVEL_MEDIUM_HIGH;
            data_qos_o.weight      = QOS_WEIGHT_MEDIUM_HIGH;
            data_qos_o.max_latency = QOS_LAT_LOAD;
            data_qos_o.urgent      = 1'b0;
            data_qos_o.preemptable = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- mem_qos_pkg.sv
`default_nettype none

package mem_qos_pkg;

    // ------------------------------------------------------------
    // Basic bus widths
    // ------------------------------------------------------------

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  strb_t;

    // Counter word shared by all monitor outputs
    typedef logic [31:0] count_t;

    // ------------------------------------------------------------
    // Request and response bundles
    // ------------------------------------------------------------

    // 69 bits on the merged channel
    typedef struct packed {
        addr_t addr;
        logic  write;
        strb_t strb;
        word_t wdata;
    } mem_req_t;

    // 33 bits, read data plus bus error
    typedef struct packed {
        word_t rdata;
        logic  error;
    } mem_rsp_t;

    // Stream that issued a request
    typedef enum logic {
        SRC_INSTR = 1'b0,
        SRC_DATA  = 1'b1
    } src_t;

    // ------------------------------------------------------------
    // QoS encodings
    // ------------------------------------------------------------

    typedef logic [2:0]  qos_level_t;
    typedef logic [3:0]  qos_weight_t;
    typedef logic [15:0] qos_latency_t;
    typedef logic [3:0]  core_id_t;

    // Levels, higher value wins arbitration
    localparam qos_level_t QOS_LEVEL_MEDIUM      = 3'd2;
    localparam qos_level_t QOS_LEVEL_MEDIUM_HIGH = 3'd3;
    localparam qos_level_t QOS_LEVEL_HIGH        = 3'd5;
    localparam qos_level_t QOS_LEVEL_CRITICAL    = 3'd7;

    // Bandwidth weights seen by the downstream arbiter
    localparam qos_weight_t QOS_WEIGHT_MEDIUM      = 4'd4;
    localparam qos_weight_t QOS_WEIGHT_MEDIUM_HIGH = 4'd6;
    localparam qos_weight_t QOS_WEIGHT_HIGH        = 4'd8;
    localparam qos_weight_t QOS_WEIGHT_CRITICAL    = 4'd15;

    // Latency bounds in cycles
    localparam qos_latency_t QOS_LAT_INSTR_NORMAL   = 16'd25;
    localparam qos_latency_t QOS_LAT_INSTR_CRITICAL = 16'd5;
    localparam qos_latency_t QOS_LAT_DATA_CRITICAL  = 16'd10;
    localparam qos_latency_t QOS_LAT_LOAD           = 16'd50;
    localparam qos_latency_t QOS_LAT_STORE          = 16'd100;

    // Sideband travelling with every forwarded request
    typedef struct packed {
        qos_level_t   level;
        logic         urgent;
        qos_weight_t  weight;
        qos_latency_t max_latency;
        core_id_t     core_id;
        logic         preemptable;
    } qos_config_t;

endpackage

`default_nettype wire
